// ==== alu_params.svh ====
/*
 * Sizing macros for the sequential ALU. The data width sets the operand and
 * result vectors, and the step count sets the multiply and divide iterations.
 */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Operand and result width
`define ALU_DATA_WIDTH 16

// Step counter, wide enough to hold ALU_STEPS - 1
`define ALU_STEP_COUNT_WIDTH 4

// One step per bit for shift-and-add and restoring division
`define ALU_STEPS 16

`endif

// ==== alu_pkg.sv ====
/*
 * Types shared between the ALU control FSM, the data path and the top level.
 */
`include "alu_params.svh"

package alu_pkg;

  // Operand or result word
  typedef logic [`ALU_DATA_WIDTH-1:0] alu_data_t;

  // Requested operation, same encoding as the input bus
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_DIV = 2'd3
  } alu_op_t;

  // Data path action for the current cycle
  typedef enum logic [2:0] {
    STEP_HOLD,
    STEP_ADD,
    STEP_SUB,
    STEP_MUL,
    STEP_NEG_A,
    STEP_NEG_B,
    STEP_DIV,
    STEP_FIX_SIGN
  } alu_step_t;

endpackage

// ==== alu_ctrl.sv ====
/*
 * ALU control. FSM, multiply/divide step counter and both valid/ready
 * handshakes. Tells the data path what to do each cycle through a step code.
 */
`timescale 1ns/100ps
`include "alu_params.svh"

module alu_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  alu_pkg::alu_op_t   i_op,
  input  logic               i_signed,
  input  logic               i_b_zero,
  input  logic               i_in_valid,
  input  logic               i_result_ready,
  output logic               o_in_ready,
  output logic               o_result_valid,
  output logic               o_error,
  output logic               o_load,
  output alu_pkg::alu_step_t o_step
);

  typedef enum logic [3:0] {
    IDLE,
    ADD,
    SUB,
    MUL_INIT,
    MUL_RUN,
    NEG_A,
    NEG_B,
    DIV_INIT,
    DIV_RUN,
    FIX_SIGN,
    DONE,
    DONE_ERR
  } state_t;

  state_t                           state_q;
  state_t                           state_d;
  logic [`ALU_STEP_COUNT_WIDTH-1:0] count_q;
  logic                             running;
  logic                             last_step;

  // Only one item in flight, so the unit accepts in IDLE only
  assign o_in_ready = (state_q == IDLE);
  assign o_load     = o_in_ready && i_in_valid;

  assign o_result_valid = (state_q == DONE) || (state_q == DONE_ERR);
  assign o_error        = (state_q == DONE_ERR);

  assign running   = (state_q == MUL_RUN) || (state_q == DIV_RUN);
  assign last_step = (count_q == '0);

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (o_load) begin
          case (i_op)
            alu_pkg::OP_ADD: state_d = ADD;
            alu_pkg::OP_SUB: state_d = SUB;
            alu_pkg::OP_MUL: state_d = MUL_INIT;
            alu_pkg::OP_DIV: begin
              // Divide by zero skips the data path entirely
              if (i_b_zero) begin
                state_d = DONE_ERR;
              end else if (i_signed) begin
                state_d = NEG_A;
              end else begin
                state_d = DIV_INIT;
              end
            end
            default: state_d = IDLE;
          endcase
        end
      end
      ADD:      state_d = DONE;
      SUB:      state_d = DONE;
      MUL_INIT: state_d = MUL_RUN;
      MUL_RUN:  state_d = last_step ? DONE : MUL_RUN;
      NEG_A:    state_d = NEG_B;
      NEG_B:    state_d = DIV_INIT;
      DIV_INIT: state_d = DIV_RUN;
      DIV_RUN:  state_d = last_step ? FIX_SIGN : DIV_RUN;
      FIX_SIGN: state_d = DONE;
      DONE, DONE_ERR: begin
        if (i_result_ready) begin
          state_d = IDLE;
        end
      end
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Counts 15 down to 0 across the run states, parked at the top otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= `ALU_STEP_COUNT_WIDTH'(`ALU_STEPS - 1);
    end else if (running) begin
      count_q <= count_q - 1'b1;
    end else begin
      count_q <= `ALU_STEP_COUNT_WIDTH'(`ALU_STEPS - 1);
    end
  end

  // State to data path step
  always_comb begin
    case (state_q)
      ADD:      o_step = alu_pkg::STEP_ADD;
      SUB:      o_step = alu_pkg::STEP_SUB;
      MUL_RUN:  o_step = alu_pkg::STEP_MUL;
      NEG_A:    o_step = alu_pkg::STEP_NEG_A;
      NEG_B:    o_step = alu_pkg::STEP_NEG_B;
      DIV_RUN:  o_step = alu_pkg::STEP_DIV;
      FIX_SIGN: o_step = alu_pkg::STEP_FIX_SIGN;
      default:  o_step = alu_pkg::STEP_HOLD;
    endcase
  end

  // Input side reopens only after the pending result has been taken
  a_ready_after_transfer: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(o_in_ready) |-> $past(o_result_valid && i_result_ready)
  ) else $error("in_ready returned without an output transfer");

  // A stalled result keeps its valid and its error flag
  a_result_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (o_result_valid && !i_result_ready) |=> (o_result_valid && $stable(o_error))
  ) else $error("result_valid dropped before the sink took it");

endmodule

// ==== alu_datapath.sv ====
/*
 * ALU data path. Operand, partial remainder and result registers around a
 * single shared adder whose operands are picked by the step code.
 */
`timescale 1ns/100ps
`include "alu_params.svh"

module alu_datapath (
  input  logic               clk,
  input  logic               rst_n,
  input  alu_pkg::alu_data_t i_a,
  input  alu_pkg::alu_data_t i_b,
  input  logic               i_signed,
  input  logic               i_load,
  input  alu_pkg::alu_step_t i_step,
  output alu_pkg::alu_data_t o_result,
  output logic               o_b_zero
);

  // Upper half is the partial remainder, lower half the dividend or multiplier
  logic [2*`ALU_DATA_WIDTH-1:0] wide_q;
  // Divisor or multiplicand
  alu_pkg::alu_data_t           b_q;
  alu_pkg::alu_data_t           result_q;
  logic                         signed_q;
  logic                         neg_q;

  alu_pkg::alu_data_t           add_x;
  alu_pkg::alu_data_t           add_y;
  logic                         add_cin;
  logic [`ALU_DATA_WIDTH:0]     add_sum;

  alu_pkg::alu_data_t           a_low;
  alu_pkg::alu_data_t           div_window;
  logic                         rem_msb;
  logic                         q_bit;
  alu_pkg::alu_data_t           div_rem;

  assign a_low = wide_q[`ALU_DATA_WIDTH-1:0];

  // Remainder shifted left with the next dividend bit, low W bits of W+1
  assign div_window = wide_q[2*`ALU_DATA_WIDTH-2:`ALU_DATA_WIDTH-1];
  assign rem_msb    = wide_q[2*`ALU_DATA_WIDTH-1];

  // Operand selection for the shared adder
  always_comb begin
    add_x   = '0;
    add_y   = '0;
    add_cin = 1'b0;
    case (i_step)
      alu_pkg::STEP_ADD: begin
        add_x = a_low;
        add_y = b_q;
      end
      alu_pkg::STEP_SUB: begin
        add_x   = a_low;
        add_y   = ~b_q;
        add_cin = 1'b1;
      end
      alu_pkg::STEP_MUL: begin
        add_x = result_q;
        add_y = b_q;
      end
      alu_pkg::STEP_NEG_A: begin
        add_x   = ~a_low;
        add_cin = 1'b1;
      end
      alu_pkg::STEP_NEG_B: begin
        add_x   = ~b_q;
        add_cin = 1'b1;
      end
      alu_pkg::STEP_DIV: begin
        // Trial subtract of the divisor from the shifted remainder
        add_x   = div_window;
        add_y   = ~b_q;
        add_cin = 1'b1;
      end
      alu_pkg::STEP_FIX_SIGN: begin
        add_x   = ~result_q;
        add_cin = 1'b1;
      end
      default: begin
        add_x = '0;
      end
    endcase
  end

  assign add_sum = {1'b0, add_x} + {1'b0, add_y} + {{`ALU_DATA_WIDTH{1'b0}}, add_cin};

  // Window >= divisor when the dropped top bit is set or the subtract carries out
  assign q_bit   = rem_msb | add_sum[`ALU_DATA_WIDTH];
  assign div_rem = q_bit ? add_sum[`ALU_DATA_WIDTH-1:0] : div_window;

  // Sign bookkeeping, captured with the operands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      signed_q <= 1'b0;
      neg_q    <= 1'b0;
    end else if (i_load) begin
      signed_q <= i_signed;
      neg_q    <= i_signed && (i_a[`ALU_DATA_WIDTH-1] ^ i_b[`ALU_DATA_WIDTH-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (i_load) begin
      wide_q <= {{`ALU_DATA_WIDTH{1'b0}}, i_a};
    end else begin
      case (i_step)
        alu_pkg::STEP_NEG_A: begin
          // Magnitude only, a positive operand stays as is
          if (signed_q && a_low[`ALU_DATA_WIDTH-1]) begin
            wide_q[`ALU_DATA_WIDTH-1:0] <= add_sum[`ALU_DATA_WIDTH-1:0];
          end
        end
        alu_pkg::STEP_MUL: wide_q <= wide_q >> 1;
        alu_pkg::STEP_DIV: wide_q <= {div_rem, wide_q[`ALU_DATA_WIDTH-2:0], 1'b0};
        default: wide_q <= wide_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_load) begin
      b_q <= i_b;
    end else begin
      case (i_step)
        alu_pkg::STEP_NEG_B: begin
          if (signed_q && b_q[`ALU_DATA_WIDTH-1]) begin
            b_q <= add_sum[`ALU_DATA_WIDTH-1:0];
          end
        end
        alu_pkg::STEP_MUL: b_q <= b_q << 1;
        default: b_q <= b_q;
      endcase
    end
  end

  // Cleared at load so a divide by zero returns zero
  always_ff @(posedge clk) begin
    if (i_load) begin
      result_q <= '0;
    end else begin
      case (i_step)
        alu_pkg::STEP_ADD, alu_pkg::STEP_SUB: begin
          result_q <= add_sum[`ALU_DATA_WIDTH-1:0];
        end
        alu_pkg::STEP_MUL: begin
          if (wide_q[0]) begin
            result_q <= add_sum[`ALU_DATA_WIDTH-1:0];
          end
        end
        alu_pkg::STEP_DIV: result_q <= {result_q[`ALU_DATA_WIDTH-2:0], q_bit};
        alu_pkg::STEP_FIX_SIGN: begin
          if (neg_q) begin
            result_q <= add_sum[`ALU_DATA_WIDTH-1:0];
          end
        end
        default: result_q <= result_q;
      endcase
    end
  end

  assign o_result = result_q;

  // Control needs this at acceptance, before the operand is registered
  assign o_b_zero = (i_b == '0);

  // Negation steps only follow a signed divide accepted earlier
  a_neg_only_signed: assert property (
    @(posedge clk) disable iff (!rst_n)
    (i_step inside {alu_pkg::STEP_NEG_A, alu_pkg::STEP_NEG_B}) |-> signed_q
  ) else $error("negation step without a signed operation");

endmodule

// ==== alu_top.sv ====
/*
 * Sequential 16-bit ALU top level. Joins the control FSM to the data path.
 * Add, subtract, multiply and divide with valid/ready on input and output.
 */
`timescale 1ns/100ps

module alu_top (
  input  logic               clk,
  input  logic               rst_n,
  input  alu_pkg::alu_data_t i_a,
  input  alu_pkg::alu_data_t i_b,
  input  alu_pkg::alu_op_t   i_op,
  input  logic               i_signed,
  input  logic               i_in_valid,
  output logic               o_in_ready,
  output alu_pkg::alu_data_t o_result,
  output logic               o_error,
  output logic               o_result_valid,
  input  logic               i_result_ready
);

  logic               load;
  logic               b_zero;
  alu_pkg::alu_step_t step;

  alu_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_op           (i_op),
    .i_signed       (i_signed),
    .i_b_zero       (b_zero),
    .i_in_valid     (i_in_valid),
    .i_result_ready (i_result_ready),
    .o_in_ready     (o_in_ready),
    .o_result_valid (o_result_valid),
    .o_error        (o_error),
    .o_load         (load),
    .o_step         (step)
  );

  alu_datapath u_datapath (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_a      (i_a),
    .i_b      (i_b),
    .i_signed (i_signed),
    .i_load   (load),
    .i_step   (step),
    .o_result (o_result),
    .o_b_zero (b_zero)
  );

endmodule

// ==== alu_tb.sv ====
/*
 * Testbench for the sequential ALU. Reads operations and expected results
 * from the stimulus file, drives both handshakes with random gaps and stalls.
 */
`timescale 1ns/100ps

module alu_tb;

  logic               clk;
  logic               rst_n;
  alu_pkg::alu_data_t i_a;
  alu_pkg::alu_data_t i_b;
  alu_pkg::alu_op_t   i_op;
  logic               i_signed;
  logic               i_in_valid;
  logic               o_in_ready;
  alu_pkg::alu_data_t o_result;
  logic               o_error;
  logic               o_result_valid;
  logic               i_result_ready;

  logic [31:0]        lcg_state;
  int                 errors;
  int                 checks;
  int                 vectors;
  logic               timed_out;

  alu_top u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_a            (i_a),
    .i_b            (i_b),
    .i_op           (i_op),
    .i_signed       (i_signed),
    .i_in_valid     (i_in_valid),
    .o_in_ready     (o_in_ready),
    .o_result       (o_result),
    .o_error        (o_error),
    .o_result_valid (o_result_valid),
    .i_result_ready (i_result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic expect_equal(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Random idle gap, then hold valid until the DUT takes the operation
  task automatic send_operation(input logic [1:0] op, input logic sgn,
                                input alu_pkg::alu_data_t a, input alu_pkg::alu_data_t b);
    int   gap;
    int   n;
    logic accepted;
    lcg_state = lcg_step(lcg_state);
    gap = lcg_state[18:16];
    accepted = 1'b0;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    i_a        <= a;
    i_b        <= b;
    i_op       <= alu_pkg::alu_op_t'(op);
    i_signed   <= sgn;
    i_in_valid <= 1'b1;
    for (n = 0; n < 100 && !accepted; n++) begin
      @(negedge clk);
      if (o_in_ready) begin
        accepted = 1'b1;
      end
    end
    assert (accepted) else begin
      errors++;
      timed_out = 1'b1;
      $display("Timed out at %0t ns waiting for o_in_ready on vector %0d", $time, vectors);
    end
    if (accepted) begin
      // Accepting edge; scramble the idle inputs so the result cannot lean on them
      @(posedge clk);
      lcg_state = lcg_step(lcg_state);
      i_in_valid <= 1'b0;
      i_a        <= lcg_state[31:16];
      i_b        <= lcg_state[15:0];
    end
  endtask

  // Random back-pressure on the result, held values checked on every stall
  task automatic collect_result(input alu_pkg::alu_data_t exp_result, input logic exp_error);
    int                 n;
    logic               taken;
    logic               stalled;
    alu_pkg::alu_data_t held_result;
    logic               held_error;
    taken   = 1'b0;
    stalled = 1'b0;
    for (n = 0; n < 100 && !taken; n++) begin
      @(posedge clk);
      lcg_state = lcg_step(lcg_state);
      i_result_ready <= lcg_state[16];
      @(negedge clk);
      expect_equal("o_in_ready", 16'h0, o_in_ready);
      if (o_result_valid) begin
        if (stalled) begin
          expect_equal("o_result (held)", held_result, o_result);
          expect_equal("o_error (held)", held_error, o_error);
        end
        if (i_result_ready) begin
          expect_equal("o_result", exp_result, o_result);
          expect_equal("o_error", exp_error, o_error);
          taken = 1'b1;
        end else begin
          stalled     = 1'b1;
          held_result = o_result;
          held_error  = o_error;
        end
      end
    end
    assert (taken) else begin
      errors++;
      timed_out = 1'b1;
      $display("Timed out at %0t ns waiting for a result on vector %0d", $time, vectors);
    end
    if (taken) begin
      // Output transfer edge
      @(posedge clk);
      i_result_ready <= 1'b0;
    end
  endtask

  initial begin
    int          fd;
    int          code;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_sgn;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_res;
    logic [31:0] f_err;
    lcg_state      = 32'd72279;
    errors         = 0;
    checks         = 0;
    vectors        = 0;
    timed_out      = 1'b0;
    rst_n          = 1'b0;
    i_a            = '0;
    i_b            = '0;
    i_op           = alu_pkg::OP_ADD;
    i_signed       = 1'b0;
    i_in_valid     = 1'b0;
    i_result_ready = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    expect_equal("o_in_ready", 16'h1, o_in_ready);
    expect_equal("o_result_valid", 16'h0, o_result_valid);
    expect_equal("o_error", 16'h0, o_error);

    fd = $fopen("alu_stimulus.txt", "r");
    assert (fd != 0) else begin
      errors++;
      $display("Could not open the stimulus file alu_stimulus.txt");
    end
    if (fd != 0) begin
      while (!$feof(fd) && !timed_out) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
          code = $sscanf(line, "%h %h %h %h %h %h", f_op, f_sgn, f_a, f_b, f_res, f_err);
          if (code == 6) begin
            send_operation(f_op[1:0], f_sgn[0], f_a[15:0], f_b[15:0]);
            if (!timed_out) begin
              collect_result(f_res[15:0], f_err[0]);
            end
            vectors++;
          end
        end
      end
      $fclose(fd);
    end
    assert (vectors > 0) else begin
      errors++;
      $display("No operations were read from the stimulus file");
    end

    $display("Vectors: %0d, checks: %0d, errors: %0d", vectors, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== seq_alu.f ====
+incdir+.
alu_pkg.sv
alu_ctrl.sv
alu_datapath.sv
alu_top.sv
alu_tb.sv

// ==== alu_stimulus.txt ====
// op signed a b expected_result expected_error, all hex
// op: 0 add, 1 sub, 2 mul, 3 div
0 0 0001 0002 0003 0
0 0 ffff 0001 0000 0
0 0 8000 8000 0000 0
0 1 7fff 0001 8000 0
0 0 1234 4321 5555 0
1 0 0005 0003 0002 0
1 0 0000 0001 ffff 0
1 0 1234 1234 0000 0
1 1 8000 0001 7fff 0
1 0 a5a5 5a5a 4b4b 0
2 0 0000 1234 0000 0
2 0 0001 abcd abcd 0
2 0 ffff ffff 0001 0
2 0 0100 0100 0000 0
2 0 00ff 00ff fe01 0
2 1 fffe 0003 fffa 0
2 1 fff9 fffb 0023 0
2 0 1234 0010 2340 0
2 0 0003 5555 ffff 0
3 0 0064 0007 000e 0
3 0 ffff 0001 ffff 0
3 0 ffff 00ff 0101 0
3 0 0005 0009 0000 0
3 0 8000 ffff 0000 0
3 0 1234 1234 0001 0
3 0 fffe 0002 7fff 0
3 1 0064 0007 000e 0
3 1 ff9c 0007 fff2 0
3 1 0064 fff9 fff2 0
3 1 ff9c fff9 000e 0
3 1 8000 ffff 8000 0
3 1 8000 0001 8000 0
3 1 fff9 0002 fffd 0
3 1 0007 fffe fffd 0
3 0 1234 0000 0000 1
0 0 0002 0003 0005 0
3 1 8000 0000 0000 1
2 0 0007 0006 002a 0
